// File: tests/cb_quant_patterns.txt
// Columns: input coefficients lane 0 to 7, then expected results lane 0 to 7
// Each word is an 11-bit two's complement value in three hex digits
// Block 0, positive coefficients
064 0C8 12C 190 1F4 258 2BC 3FF 006 00B 00D 008 005 006 007 00A
032 03C 046 050 05A 06E 078 082 003 003 003 001 001 001 001 001
018 01A 038 064 096 0FA 15E 1C2 001 001 001 001 002 003 004 005
3E8 384 320 2BC 258 1F4 190 12C 015 00E 008 007 006 005 004 003
064 0C8 12C 190 1F4 258 2BC 320 001 002 003 004 005 006 007 008
384 3E8 3FF 000 032 019 00A 001 009 00A 00A 000 001 000 000 000
031 032 063 096 0FA 15E 1C2 226 000 001 001 002 003 004 005 006
095 097 000 000 000 000 000 000 001 002 000 000 000 000 000 000
// Block 1, the same magnitudes negated
79C 738 6D4 670 60C 5A8 544 401 7FA 7F5 7F3 7F8 7FB 7FA 7F9 7F6
7CE 7C4 7BA 7B0 7A6 792 788 77E 7FD 7FD 7FD 7FF 7FF 7FF 7FF 7FF
7E8 7E6 7C8 79C 76A 706 6A2 63E 7FF 7FF 7FF 7FF 7FE 7FD 7FC 7FB
418 47C 4E0 544 5A8 60C 670 6D4 7EB 7F2 7F8 7F9 7FA 7FB 7FC 7FD
79C 738 6D4 670 60C 5A8 544 4E0 7FF 7FE 7FD 7FC 7FB 7FA 7F9 7F8
47C 418 401 000 7CE 7E7 7F6 7FF 7F7 7F6 7F6 000 7FF 000 000 000
7CF 7CE 79D 76A 706 6A2 63E 5DA 000 7FF 7FF 7FE 7FD 7FC 7FB 7FA
76B 769 000 000 000 000 000 000 7FF 7FE 000 000 000 000 000 000
// Block 2, rounding just below, at and above one half
008 200 00C 7E8 7CE 7CF 3FF 400 000 01D 001 7FF 7FF 000 00A 7F6
600 00B 400 400 019 033 7CD 063 7E4 001 7D9 7F1 000 001 7FF 001
400 3FF 7E3 3E8 418 1F4 60C 000 7D5 027 7FF 00A 7F6 005 7FB 000
3FF 400 400 021 096 76A 79C 001 016 7F1 7F6 000 002 7FE 7FF 000
031 032 095 096 0F9 0FA 15D 15E 000 001 001 002 002 003 003 004
7CF 7CE 76B 76A 707 706 6A3 6A2 000 7FF 7FF 7FE 7FE 7FD 7FD 7FC
1C1 1C2 225 226 289 28A 2ED 2EE 004 005 005 006 006 007 007 008
351 352 3B5 3B6 3FF 400 401 000 008 009 009 00A 00A 7F6 7F6 000
// Block 3, full scale coefficients and small values
3FF 400 3FF 400 3FF 400 3FF 400 03C 7C7 02B 7EA 00A 7F6 00A 7F6
400 3FF 400 3FF 400 3FF 400 3FF 7C7 031 7D9 00F 7F6 00A 7F6 00A
3FF 3FF 3FF 3FF 400 400 400 400 02B 027 012 00A 7F6 7F6 7F6 7F6
400 400 400 400 3FF 3FF 3FF 3FF 7EA 7F1 7F6 7F6 00A 00A 00A 00A
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
001 001 001 001 001 001 001 001 000 000 000 000 000 000 000 000
7FF 7FF 7FF 7FF 7FF 7FF 7FF 7FF 000 000 000 000 000 000 000 000
3FF 3FF 3FF 3FF 400 400 400 400 00A 00A 00A 00A 7F6 7F6 7F6 7F6

// File: flist.f
+incdir+hw
hw/cb_quant_data_pkg.sv
hw/cb_quant_flow_pkg.sv
hw/cb_row_feeder.sv
hw/cb_quant_lane.sv
hw/cb_row_drain.sv
hw/cb_quant_top.sv
tests/tb_cb_quant.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_cb_quant
RTL_TOP    = cb_quant_top
FLIST      = flist.f
PASS_MSG   = Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf obj_dir

// File: tests/tb_cb_quant.sv
// Testbench for the Cb quantizer
// Replays the pattern file through the DUT with random source and sink stalls,
// checking every output row, its row index and the credit accounting

`timescale 1ns/100ps
`include "cb_quant_defines.svh"

module tb_cb_quant;

    localparam int NUM_ROWS       = 4 * `CB_ROWS;
    localparam int FIELDS         = 2 * `CB_LANES;
    localparam int TIMEOUT_CYCLES = 5000;

    logic                         clk;
    logic                         rst;
    logic                         in_valid;
    cb_quant_data_pkg::coef_row_t in_coefs;
    logic                         out_credit;
    logic                         in_credit;
    logic                         out_valid;
    cb_quant_data_pkg::row_idx_t  out_row;
    cb_quant_data_pkg::coef_row_t out_coefs;

    // One 12-bit word per coefficient, sixteen words per pattern line
    logic [11:0] pat_mem [0:NUM_ROWS*FIELDS-1];

    cb_quant_data_pkg::coef_row_t exp_q [$];
    cb_quant_data_pkg::row_idx_t  row_q [$];

    int src_credit;
    int sink_held;
    int rows_sent;
    int rows_recv;
    int grants;
    int valid_cnt;
    int in_credit_cnt;
    int value_errors;
    int other_errors;

    cb_quant_top i_cb_quant_top (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_coefs   (in_coefs),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_row    (out_row),
        .out_coefs  (out_coefs)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Base 0 picks the input half of a line, base CB_LANES the expected half
    function automatic cb_quant_data_pkg::coef_row_t row_field(input int row, input int base);
        cb_quant_data_pkg::coef_row_t r;
        for (int l = 0; l < `CB_LANES; l++) begin
            r[l*`CB_COEF_W +: `CB_COEF_W] = pat_mem[row*FIELDS + base + l][`CB_COEF_W-1:0];
        end
        return r;
    endfunction

    task automatic check_row();
        cb_quant_data_pkg::coef_row_t exp_row;
        cb_quant_data_pkg::row_idx_t  exp_idx;
        valid_cnt++;
        rows_recv++;
        sink_held--;
        assert (valid_cnt <= grants) else begin
            $display("More rows were sent downstream than credits were granted");
            other_errors++;
        end
        assert (exp_q.size() != 0) else begin
            $display("A row arrived downstream that was never sent");
            other_errors++;
        end
        if (exp_q.size() != 0) begin
            exp_row = exp_q.pop_front();
            exp_idx = row_q.pop_front();
            assert (out_coefs === exp_row) else begin
                $display("Fail out_coefs expected %h actual %h", exp_row, out_coefs);
                value_errors++;
            end
            assert (out_row === exp_idx) else begin
                $display("Fail out_row expected %h actual %h", exp_idx, out_row);
                value_errors++;
            end
        end
    endtask

    // Each clock accounts for what the DUT took, observes outputs and drives the next inputs
    task automatic step(input int send_pct, input int grant_pct);
        bit          do_send;
        bit          do_grant;
        int unsigned send_rnd;
        int unsigned grant_rnd;
        @(posedge clk);
        #1;
        if (in_valid) begin
            src_credit--;
            rows_sent++;
        end
        if (out_credit) begin
            sink_held++;
            grants++;
        end
        if (out_valid) begin
            check_row();
        end
        if (in_credit) begin
            src_credit++;
            in_credit_cnt++;
        end
        assert (src_credit >= 0 && src_credit <= `CB_ROW_FIFO_DEPTH) else begin
            $display("The source credit count left the range from zero to the buffer depth");
            other_errors++;
        end
        send_rnd  = $urandom % 100;
        grant_rnd = $urandom % 100;
        do_send  = (src_credit > 0) && (rows_sent < NUM_ROWS) && (send_rnd < send_pct);
        do_grant = (sink_held < `CB_ROW_FIFO_DEPTH) && (grant_rnd < grant_pct);
        if (do_send) begin
            in_coefs = row_field(rows_sent, 0);
            exp_q.push_back(row_field(rows_sent, `CB_LANES));
            row_q.push_back(cb_quant_data_pkg::row_idx_t'(rows_sent % `CB_ROWS));
        end
        in_valid   = do_send;
        out_credit = do_grant;
    endtask

    initial begin
        int cycles;
        void'($urandom(32'h115af834));
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_coefs      = '0;
        out_credit    = 1'b0;
        src_credit    = `CB_ROW_FIFO_DEPTH;
        sink_held     = 0;
        rows_sent     = 0;
        rows_recv     = 0;
        grants        = 0;
        valid_cnt     = 0;
        in_credit_cnt = 0;
        value_errors  = 0;
        other_errors  = 0;
        $readmemh("tests/cb_quant_patterns.txt", pat_mem);

        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        // Nothing may come out without input
        for (cycles = 0; cycles < 20; cycles++) begin
            step(0, 0);
            assert (!out_valid && !in_credit) else begin
                $display("Output activity was seen while the DUT was idle");
                other_errors++;
            end
        end

        // Downstream withholds credit, so the source must stop after the buffer fills
        for (cycles = 0; cycles < 40; cycles++) begin
            step(100, 0);
        end
        assert (rows_sent == `CB_ROW_FIFO_DEPTH && rows_recv == 0) else begin
            $display("With no downstream credit %0d rows were accepted and %0d delivered",
                     rows_sent, rows_recv);
            other_errors++;
        end

        cycles = 0;
        while (rows_recv < NUM_ROWS && cycles < TIMEOUT_CYCLES) begin
            step(70, 50);
            cycles++;
        end
        if (rows_recv < NUM_ROWS) begin
            $display("Timed out waiting for output rows, %0d of %0d received",
                     rows_recv, NUM_ROWS);
            other_errors++;
        end

        // Keep granting for a while so any extra row would show up
        for (cycles = 0; cycles < 30; cycles++) begin
            step(0, 50);
        end

        assert (in_credit_cnt == rows_recv) else begin
            $display("Upstream got %0d credits back for %0d rows delivered",
                     in_credit_cnt, rows_recv);
            other_errors++;
        end
        assert (src_credit == `CB_ROW_FIFO_DEPTH && exp_q.size() == 0) else begin
            $display("The source did not end with all its credits and no rows pending");
            other_errors++;
        end

        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: hw/cb_quant_top.sv
// Cb quantizer top level
// Row feeder, one arithmetic lane per column and the credit-managed drain

`timescale 1ns/100ps
`include "cb_quant_defines.svh"

module cb_quant_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    input  cb_quant_data_pkg::coef_row_t in_coefs,
    input  logic                         out_credit,
    output logic                         in_credit,
    output logic                         out_valid,
    output cb_quant_data_pkg::row_idx_t  out_row,
    output cb_quant_data_pkg::coef_row_t out_coefs
);

    cb_quant_data_pkg::coef_row_t  lane_coefs;
    cb_quant_data_pkg::recip_row_t lane_recips;
    cb_quant_data_pkg::coef_row_t  lane_results;
    logic                          feed_valid;
    cb_quant_data_pkg::row_idx_t   feed_row;

    cb_row_feeder i_feeder (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_coefs    (in_coefs),
        .lane_coefs  (lane_coefs),
        .lane_recips (lane_recips),
        .feed_valid  (feed_valid),
        .feed_row    (feed_row)
    );

    // Lane n handles column n of every row
    for (genvar lane = 0; lane < `CB_LANES; lane++) begin : g_lane
        cb_quant_lane i_lane (
            .clk    (clk),
            .rst    (rst),
            .coef   (lane_coefs[lane*`CB_COEF_W +: `CB_COEF_W]),
            .recip  (lane_recips[lane*`CB_RECIP_W +: `CB_RECIP_W]),
            .result (lane_results[lane*`CB_COEF_W +: `CB_COEF_W])
        );
    end

    cb_row_drain i_drain (
        .clk          (clk),
        .rst          (rst),
        .lane_results (lane_results),
        .feed_valid   (feed_valid),
        .feed_row     (feed_row),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_row      (out_row),
        .out_coefs    (out_coefs),
        .in_credit    (in_credit)
    );

endmodule

// File: hw/cb_row_drain.sv
// Cb quantizer row drain
// Lines up lane results with their row index, buffers finished rows and
// sends them downstream against credits; each freed slot is returned upstream

`timescale 1ns/100ps
`include "cb_quant_defines.svh"

module cb_row_drain (
    input  logic                         clk,
    input  logic                         rst,
    input  cb_quant_data_pkg::coef_row_t lane_results,
    input  logic                         feed_valid,
    input  cb_quant_data_pkg::row_idx_t  feed_row,
    input  logic                         out_credit,
    output logic                         out_valid,
    output cb_quant_data_pkg::row_idx_t  out_row,
    output cb_quant_data_pkg::coef_row_t out_coefs,
    output logic                         in_credit
);

    logic [`CB_LANE_STAGES-1:0]  valid_pipe;
    cb_quant_data_pkg::row_idx_t row_pipe [`CB_LANE_STAGES];

    cb_quant_data_pkg::coef_row_t row_mem [`CB_ROW_FIFO_DEPTH];
    cb_quant_data_pkg::row_idx_t  idx_mem [`CB_ROW_FIFO_DEPTH];

    cb_quant_flow_pkg::fifo_ptr_t   wr_ptr;
    cb_quant_flow_pkg::fifo_ptr_t   rd_ptr;
    cb_quant_flow_pkg::fifo_cnt_t   fill;
    cb_quant_flow_pkg::credit_cnt_t credits;

    logic push;
    logic pop;

    // Follow the row through the lane pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[`CB_LANE_STAGES-2:0], feed_valid};
        end
    end

    always_ff @(posedge clk) begin
        row_pipe[0] <= feed_row;
        for (int i = 1; i < `CB_LANE_STAGES; i++) begin
            row_pipe[i] <= row_pipe[i-1];
        end
    end

    assign push = valid_pipe[`CB_LANE_STAGES-1];
    assign pop  = (fill != '0) && (credits != '0);

    // Upstream credits guarantee a free slot for every row in flight
    always_ff @(posedge clk) begin
        if (push) begin
            row_mem[wr_ptr] <= lane_results;
            idx_mem[wr_ptr] <= row_pipe[`CB_LANE_STAGES-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill <= '0;
        end else begin
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // A credit is spent when the row is popped, one cycle before out_valid
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= '0;
        end else begin
            case ({out_credit, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_coefs <= row_mem[rd_ptr];
            out_row   <= idx_mem[rd_ptr];
        end
    end

    // The slot of every row sent is free again
    assign in_credit = out_valid;

endmodule

// File: hw/cb_quant_lane.sv
// Cb quantizer lane
// Divides one coefficient by its table entry through a scaled reciprocal:
// sign-extend, multiply, then round and drop the fraction bits

`timescale 1ns/100ps
`include "cb_quant_defines.svh"

module cb_quant_lane (
    input  logic                     clk,
    input  logic                     rst,
    input  cb_quant_data_pkg::coef_t  coef,
    input  cb_quant_data_pkg::recip_t recip,
    output cb_quant_data_pkg::coef_t  result
);

    logic signed [`CB_PROD_W-1:0] coef_ext;
    logic signed [`CB_PROD_W-1:0] recip_ext;
    cb_quant_data_pkg::product_t  prod_q;

    // Stage 1: coefficient is two's complement, reciprocal is unsigned
    always_ff @(posedge clk) begin
        if (rst) begin
            coef_ext  <= '0;
            recip_ext <= '0;
        end else begin
            coef_ext  <= {{(`CB_PROD_W-`CB_COEF_W){coef[`CB_COEF_W-1]}}, coef};
            recip_ext <= {{(`CB_PROD_W-`CB_RECIP_W){1'b0}}, recip};
        end
    end

    // Stage 2: only the low CB_PROD_W bits of the product are kept
    always_ff @(posedge clk) begin
        if (rst) begin
            prod_q <= '0;
        end else begin
            prod_q <= coef_ext * recip_ext;
        end
    end

    // Stage 3: round half up on the bit below the shift, wrapping in 11 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= prod_q[`CB_PROD_W-1:`CB_FRAC_BITS]
                    + {{(`CB_COEF_W-1){1'b0}}, prod_q[`CB_FRAC_BITS-1]};
        end
    end

endmodule

// File: hw/cb_row_feeder.sv
// Cb quantizer row feeder
// Registers each accepted row, tracks its position in the 8x8 block and
// presents the matching row of Cb reciprocals to the lanes

`timescale 1ns/100ps
`include "cb_quant_defines.svh"

module cb_row_feeder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  cb_quant_data_pkg::coef_row_t  in_coefs,
    output cb_quant_data_pkg::coef_row_t  lane_coefs,
    output cb_quant_data_pkg::recip_row_t lane_recips,
    output logic                          feed_valid,
    output cb_quant_data_pkg::row_idx_t   feed_row
);

    // round(4096 / q) over the standard JPEG chrominance table, row major
    localparam cb_quant_data_pkg::recip_t RECIP_TABLE [`CB_ROWS*`CB_LANES] = '{
        241, 228, 171,  87,  41,  41,  41,  41,
        228, 195, 158,  62,  41,  41,  41,  41,
        171, 158,  73,  41,  41,  41,  41,  41,
         87,  62,  41,  41,  41,  41,  41,  41,
         41,  41,  41,  41,  41,  41,  41,  41,
         41,  41,  41,  41,  41,  41,  41,  41,
         41,  41,  41,  41,  41,  41,  41,  41,
         41,  41,  41,  41,  41,  41,  41,  41
    };

    cb_quant_data_pkg::row_idx_t row_cnt;

    // Position of the next row to arrive
    always_ff @(posedge clk) begin
        if (rst) begin
            row_cnt <= '0;
        end else if (in_valid) begin
            if (row_cnt == cb_quant_data_pkg::row_idx_t'(`CB_ROWS - 1)) begin
                row_cnt <= '0;
            end else begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            feed_valid <= 1'b0;
            feed_row   <= '0;
        end else begin
            feed_valid <= in_valid;
            if (in_valid) begin
                feed_row <= row_cnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            lane_coefs <= in_coefs;
        end
    end

    // Reciprocal row follows the registered row index, so it lines up with lane_coefs
    always_comb begin
        for (int lane = 0; lane < `CB_LANES; lane++) begin
            lane_recips[lane*`CB_RECIP_W +: `CB_RECIP_W] =
                RECIP_TABLE[feed_row*`CB_LANES + lane];
        end
    end

endmodule

// File: hw/cb_quant_flow_pkg.sv
// Cb quantizer flow-control types
// Credit counters and row buffer pointers

`include "cb_quant_defines.svh"

package cb_quant_flow_pkg;

    // Downstream credits currently held
    typedef logic [$clog2(`CB_ROW_FIFO_DEPTH):0] credit_cnt_t;

    // Read or write slot in the row buffer
    typedef logic [$clog2(`CB_ROW_FIFO_DEPTH)-1:0] fifo_ptr_t;

    // Rows held in the buffer, empty through full
    typedef logic [$clog2(`CB_ROW_FIFO_DEPTH):0] fifo_cnt_t;

endpackage

// File: hw/cb_quant_data_pkg.sv
// Cb quantizer data-path types
// Coefficients, reciprocals, products and the packed rows that carry them

`include "cb_quant_defines.svh"

package cb_quant_data_pkg;

    // One signed coefficient or quantized result
    typedef logic signed [`CB_COEF_W-1:0] coef_t;

    // One scaled reciprocal, always positive
    typedef logic [`CB_RECIP_W-1:0] recip_t;

    // Signed product truncated to the bits that matter for rounding
    typedef logic signed [`CB_PROD_W-1:0] product_t;

    // A row of coefficients, lane 0 in the low bits
    typedef logic [`CB_LANES*`CB_COEF_W-1:0] coef_row_t;

    // A row of reciprocals, lane 0 in the low bits
    typedef logic [`CB_LANES*`CB_RECIP_W-1:0] recip_row_t;

    // Row position inside a block
    typedef logic [$clog2(`CB_ROWS)-1:0] row_idx_t;

endpackage

// File: hw/cb_quant_defines.svh
// Cb quantizer parameters
// Data-path widths, block geometry, lane pipeline depth and the row buffer
// depth shared by the quantizer packages and modules

`ifndef CB_QUANT_DEFINES_SVH
`define CB_QUANT_DEFINES_SVH

// Two's complement DCT coefficient and quantized result
`define CB_COEF_W 11

// Reciprocal of a table entry, scaled by 4096
`define CB_RECIP_W 13

// Product kept for rounding
`define CB_PROD_W 23

// Scaling shift; the rounding bit sits just below it
`define CB_FRAC_BITS 12

// Coefficients per row, one lane each
`define CB_LANES 8

// Rows per 8x8 block
`define CB_ROWS 8

// Register stages inside one lane
`define CB_LANE_STAGES 3

// Rows held by the drain buffer, also the upstream credit at reset
`define CB_ROW_FIFO_DEPTH 4

`endif
